/* sim.f */
+incdir+common
common/pipe_pkg.sv
verilog/phys_reg_file.sv
verilog/forward_unit.sv
verilog/read_stage.sv
execute/alu_stage.sv
execute/mem_stage.sv
verilog/operand_pipe_top.sv
bench/tb_operand_pipe.sv

/* Bender.yml */
package:
  name: operand_pipe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pipe_pkg.sv
      - verilog/phys_reg_file.sv
      - verilog/forward_unit.sv
      - verilog/read_stage.sv
      - execute/alu_stage.sv
      - execute/mem_stage.sv
      - verilog/operand_pipe_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_operand_pipe.sv

/* bench/tb_operand_pipe.sv */
// Loads only read words stored earlier because the data memory powers up unknown; issue never idles
`timescale 1ns/100ps
`default_nettype none

`include "pipe_cfg.svh"

module tb_operand_pipe;
	import pipe_pkg::*;

	localparam int NUM_INSTR  = 400;
	localparam int MAX_CYCLES = NUM_INSTR * 2 + 50;

	// One pending writeback
	typedef struct packed {
		phys_idx_t   phys;
		data_word_t  data;
		logic [31:0] cycle;
	} wb_expect_t;

	logic       clk, reset, issue_valid, uses_rs, uses_rt, writes_rd, is_load, is_store, use_imm;
	phys_idx_t  rs_phys, rt_phys, rd_phys, wb_phys, load_rd;
	alu_op_t    alu_op;
	imm_t       imm;
	logic       issue_ready, wb_valid, load_in_ex, finished, pending_new;
	data_word_t wb_data;

	// Reference model state
	data_word_t model_regs [`PIPE_PHYS_REGS];
	data_word_t model_mem [`PIPE_MEM_WORDS];
	logic       written [`PIPE_MEM_WORDS];
	mem_addr_t  last_store_addr;
	logic       last_store_valid = 1'b0;
	wb_expect_t exp_q [$];

	integer seed = 32'hc34f_ff6e;
	int cycle = 0, issued = 0, stalls = 0, pair_hits = 0, drain = 0;
	int value_errors = 0, order_errors = 0, coverage_errors = 0, timeout_errors = 0;

	operand_pipe_top operand_pipe_top_i (.clk, .reset, .issue_valid, .uses_rs, .uses_rt, .rs_phys,
		.rt_phys, .writes_rd, .rd_phys, .is_load, .is_store, .use_imm, .alu_op, .imm,
		.issue_ready, .wb_valid, .wb_phys, .wb_data);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Signed immediate widened to a word
	function automatic data_word_t sext_imm(imm_t v);
		return int'(v);
	endfunction

	function automatic data_word_t alu_eval(alu_op_t op, data_word_t a, data_word_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			// Signed compare
			ALU_SLT: return (int'(a) < int'(b)) ? 1 : 0;
			default: return 'x;
		endcase
	endfunction

	task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		value_errors++;
	endtask

	task automatic drive_idle();
		issue_valid = 1'b0;
		uses_rs     = 1'b0;
		uses_rt     = 1'b0;
		writes_rd   = 1'b0;
		is_load     = 1'b0;
		is_store    = 1'b0;
		use_imm     = 1'b0;
		rs_phys     = '0;
		rt_phys     = '0;
		rd_phys     = '0;
		alu_op      = ALU_ADD;
		imm         = '0;
	endtask

	// Next instruction from the current model state
	task automatic make_instr(int n);
		logic [31:0] r;
		logic [31:0] k;
		logic [2:0]  op_sel;
		mem_addr_t   target;
		r           = $random(seed);
		k           = $random(seed);
		issue_valid = 1'b1;
		uses_rs     = 1'b1;
		is_load     = 1'b0;
		is_store    = 1'b0;
		imm         = k[15:0];
		if (n < `PIPE_PHYS_REGS)
		begin
			// Sweep of or rN, rN, 0 shows every register starts at zero
			rs_phys   = phys_idx_t'(n);
			rt_phys   = phys_idx_t'(n);
			rd_phys   = phys_idx_t'(n);
			uses_rt   = 1'b0;
			writes_rd = 1'b1;
			use_imm   = 1'b1;
			alu_op    = ALU_OR;
			imm       = '0;
			return;
		end
		// Eight registers only, so neighbours depend on each other often
		rs_phys = r[2:0];
		rt_phys = r[5:3];
		rd_phys = r[8:6];
		target  = r[11:9];
		op_sel  = r[14:12];
		if (op_sel > 3'd5)
			op_sel = op_sel - 3'd6;
		alu_op    = alu_op_t'(op_sel);
		use_imm   = r[15];
		uses_rt   = ~r[15];
		writes_rd = (r[19:16] != 4'd0);
		if (r[22:20] < 3'd3)
		begin
			// Low immediate bits steer the address into words 0 to 7
			imm[`PIPE_ADDR_BITS-1:0] = target - model_regs[rs_phys][`PIPE_ADDR_BITS-1:0];
			alu_op    = ALU_ADD;
			use_imm   = 1'b1;
			is_load   = written[target] && (r[22:20] != 3'd0);
			is_store  = ~is_load;
			uses_rt   = is_store;
			writes_rd = is_load;
		end
	endtask

	// In-order execution at acceptance
	task automatic model_accept();
		data_word_t b;
		data_word_t res;
		mem_addr_t  addr;
		wb_expect_t e;
		b    = use_imm ? sext_imm(imm) : model_regs[rt_phys];
		res  = alu_eval(alu_op, model_regs[rs_phys], b);
		addr = res[`PIPE_ADDR_BITS-1:0];
		if (is_store)
		begin
			model_mem[addr]  = model_regs[rt_phys];
			written[addr]    = 1'b1;
			last_store_addr  = addr;
			last_store_valid = 1'b1;
		end
		else if (writes_rd)
		begin
			if (is_load)
			begin
				res = model_mem[addr];
				// Load reading back the most recent store
				if (last_store_valid && addr == last_store_addr)
					pair_hits++;
			end
			model_regs[rd_phys] = res;
			e.phys  = rd_phys;
			e.data  = res;
			e.cycle = cycle;
			exp_q.push_back(e);
		end
	endtask

	task automatic check_writeback();
		wb_expect_t e;
		if (wb_valid === 1'b0)
			return;
		if (exp_q.size() == 0)
		begin
			$display("Writeback to register %0d at %0t with no instruction pending", wb_phys, $time);
			order_errors++;
			return;
		end
		e = exp_q.pop_front();
		if (wb_phys !== e.phys)
			report_mismatch("wb_phys", e.phys, wb_phys);
		if (wb_data !== e.data)
			report_mismatch("wb_data", e.data, wb_data);
		if (cycle - e.cycle != 3)
			report_mismatch("wb latency in cycles", 3, cycle - e.cycle);
	endtask

	initial
	begin
		logic exp_ready;
		reset       = 1'b1;
		load_in_ex  = 1'b0;
		finished    = 1'b0;
		pending_new = 1'b0;
		drive_idle();
		for (int i = 0; i < `PIPE_PHYS_REGS; i++)
			model_regs[i] = '0;
		for (int i = 0; i < `PIPE_MEM_WORDS; i++)
			written[i] = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		make_instr(0);
		while (!finished)
		begin
			// All outputs settled by mid cycle
			@(negedge clk);
			check_writeback();
			// Stall only when last cycle's load feeds a used source
			exp_ready = !(load_in_ex && ((uses_rs && rs_phys == load_rd)
				|| (uses_rt && rt_phys == load_rd)));
			if (issue_valid && issue_ready !== exp_ready)
				report_mismatch("issue_ready", exp_ready, issue_ready);
			load_in_ex = 1'b0;
			if (issue_valid && issue_ready)
			begin
				model_accept();
				load_in_ex  = is_load;
				load_rd     = rd_phys;
				pending_new = 1'b1;
				issued++;
			end
			else if (issue_valid)
				stalls++;
			// A few quiet cycles catch stray writebacks
			if (issued == NUM_INSTR && exp_q.size() == 0)
				drain++;
			cycle++;
			if (drain >= 4)
				finished = 1'b1;
			else if (cycle >= MAX_CYCLES)
			begin
				$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
				timeout_errors++;
				finished = 1'b1;
			end
			@(posedge clk);
			#1;
			if (pending_new)
			begin
				pending_new = 1'b0;
				if (issued < NUM_INSTR)
					make_instr(issued);
				else
					drive_idle();
			end
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d expected writebacks never arrived", exp_q.size());
			order_errors++;
		end
		if (stalls == 0)
		begin
			$display("The instruction stream never caused a load-use stall");
			coverage_errors++;
		end
		if (pair_hits == 0)
		begin
			$display("No load read back the word of the store before it");
			coverage_errors++;
		end
		$display("Errors: %0d value, %0d order, %0d coverage, %0d timeout (%0d issued, %0d stalls)",
			value_errors, order_errors, coverage_errors, timeout_errors, issued, stalls);
		if (value_errors + order_errors + coverage_errors + timeout_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/operand_pipe_top.sv */
// Three cycle issue-to-writeback latency; issue_ready drops only on a load-use hazard
`timescale 1ns/100ps
`default_nettype none

module operand_pipe_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  logic                 uses_rs,
	input  logic                 uses_rt,
	input  pipe_pkg::phys_idx_t  rs_phys,
	input  pipe_pkg::phys_idx_t  rt_phys,
	input  logic                 writes_rd,
	input  pipe_pkg::phys_idx_t  rd_phys,
	input  logic                 is_load,
	input  logic                 is_store,
	input  logic                 use_imm,
	input  pipe_pkg::alu_op_t    alu_op,
	input  pipe_pkg::imm_t       imm,
	output logic                 issue_ready,
	output logic                 wb_valid,
	output pipe_pkg::phys_idx_t  wb_phys,
	output pipe_pkg::data_word_t wb_data
);
	import pipe_pkg::*;

	// Register file to forward unit
	data_word_t rs_value, rt_value;
	// Forward unit to read stage
	data_word_t rs_data, rt_data;
	logic       load_hazard;
	// EX stage
	logic       ex_valid, ex_writes, ex_is_load, ex_is_store, ex_use_imm;
	phys_idx_t  ex_rd;
	alu_op_t    ex_op;
	imm_t       ex_imm;
	data_word_t ex_rs_data, ex_rt_data, ex_result;
	// MEM stage
	logic       mem_valid, mem_writes, mem_is_load, mem_is_store;
	phys_idx_t  mem_rd;
	data_word_t mem_alu, mem_store_data, mem_result;

	// WB port writes the file and feeds forwarding
	phys_reg_file phys_reg_file_i (.clk, .reset, .rs_phys, .rt_phys, .rs_value, .rt_value,
		.wr_en(wb_valid), .wr_phys(wb_phys), .wr_data(wb_data));

	forward_unit forward_unit_i (.uses_rs, .uses_rt, .rs_phys, .rt_phys, .rs_value, .rt_value,
		.ex_valid, .ex_writes, .ex_is_load, .ex_rd, .ex_result,
		.mem_valid, .mem_writes, .mem_rd, .mem_result,
		.wb_valid, .wb_phys, .wb_data, .rs_data, .rt_data, .load_hazard);

	read_stage read_stage_i (.clk, .reset, .issue_valid, .writes_rd, .rd_phys, .is_load,
		.is_store, .use_imm, .alu_op, .imm, .rs_data, .rt_data, .load_hazard, .issue_ready,
		.ex_valid, .ex_writes, .ex_is_load, .ex_is_store, .ex_use_imm, .ex_rd, .ex_op,
		.ex_imm, .ex_rs_data, .ex_rt_data);

	alu_stage alu_stage_i (.clk, .reset, .ex_valid, .ex_writes, .ex_is_load, .ex_is_store,
		.ex_use_imm, .ex_rd, .ex_op, .ex_imm, .ex_rs_data, .ex_rt_data, .ex_result,
		.mem_valid, .mem_writes, .mem_is_load, .mem_is_store, .mem_rd, .mem_alu,
		.mem_store_data);

	mem_stage mem_stage_i (.clk, .reset, .mem_valid, .mem_writes, .mem_is_load,
		.mem_is_store, .mem_rd, .mem_alu, .mem_store_data, .mem_result,
		.wb_valid, .wb_phys, .wb_data);

endmodule

`default_nettype wire

/* execute/mem_stage.sv */
// Data memory is uninitialized and indexed by the low address bits; upper bits ignored
`timescale 1ns/100ps
`default_nettype none

`include "pipe_cfg.svh"

module mem_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 mem_valid,
	input  logic                 mem_writes,
	input  logic                 mem_is_load,
	input  logic                 mem_is_store,
	input  pipe_pkg::phys_idx_t  mem_rd,
	input  pipe_pkg::data_word_t mem_alu,
	input  pipe_pkg::data_word_t mem_store_data,
	output pipe_pkg::data_word_t mem_result,
	output logic                 wb_valid,
	output pipe_pkg::phys_idx_t  wb_phys,
	output pipe_pkg::data_word_t wb_data
);
	import pipe_pkg::*;

	data_word_t dmem [`PIPE_MEM_WORDS];
	mem_addr_t  addr;
	logic       store_en;

	assign addr     = mem_alu[`PIPE_ADDR_BITS-1:0];
	assign store_en = mem_valid & mem_is_store;

	// Store lands at the end of the MEM cycle
	always_ff @(posedge clk)
	begin
		if (store_en)
			dmem[addr] <= mem_store_data;
	end

	// Load read is combinational, so forwarding sees it in MEM
	assign mem_result = mem_is_load ? dmem[addr] : mem_alu;

	// Stores never write back
	always_ff @(posedge clk)
	begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= mem_valid & mem_writes & ~mem_is_store;
	end

	always_ff @(posedge clk)
	begin
		wb_phys <= mem_rd;
		wb_data <= mem_result;
	end

endmodule

`default_nettype wire

/* execute/alu_stage.sv */
// ALU plus EX/MEM register; immediate sign extended, SLT signed, loads/stores add for the address
`timescale 1ns/100ps
`default_nettype none

`include "pipe_cfg.svh"

module alu_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ex_valid,
	input  logic                 ex_writes,
	input  logic                 ex_is_load,
	input  logic                 ex_is_store,
	input  logic                 ex_use_imm,
	input  pipe_pkg::phys_idx_t  ex_rd,
	input  pipe_pkg::alu_op_t    ex_op,
	input  pipe_pkg::imm_t       ex_imm,
	input  pipe_pkg::data_word_t ex_rs_data,
	input  pipe_pkg::data_word_t ex_rt_data,
	output pipe_pkg::data_word_t ex_result,
	output logic                 mem_valid,
	output logic                 mem_writes,
	output logic                 mem_is_load,
	output logic                 mem_is_store,
	output pipe_pkg::phys_idx_t  mem_rd,
	output pipe_pkg::data_word_t mem_alu,
	output pipe_pkg::data_word_t mem_store_data
);
	import pipe_pkg::*;

	data_word_t imm_ext;
	data_word_t op_b;

	// Sign extend immediate to a full word
	assign imm_ext = {{(`PIPE_DATA_WIDTH - `PIPE_IMM_WIDTH){ex_imm[`PIPE_IMM_WIDTH-1]}}, ex_imm};
	assign op_b    = ex_use_imm ? imm_ext : ex_rt_data;

	always_comb
	begin
		case (ex_op)
			ALU_ADD: ex_result = ex_rs_data + op_b;
			ALU_SUB: ex_result = ex_rs_data - op_b;
			ALU_AND: ex_result = ex_rs_data & op_b;
			ALU_OR:  ex_result = ex_rs_data | op_b;
			ALU_XOR: ex_result = ex_rs_data ^ op_b;
			ALU_SLT: ex_result = ($signed(ex_rs_data) < $signed(op_b)) ? 'd1 : '0;
			default: ex_result = '0;
		endcase
	end

	// EX/MEM valid
	always_ff @(posedge clk)
	begin
		if (reset)
			mem_valid <= 1'b0;
		else
			mem_valid <= ex_valid;
	end

	// EX/MEM payload; store data is the rt operand
	always_ff @(posedge clk)
	begin
		mem_writes     <= ex_writes;
		mem_is_load    <= ex_is_load;
		mem_is_store   <= ex_is_store;
		mem_rd         <= ex_rd;
		mem_alu        <= ex_result;
		mem_store_data <= ex_rt_data;
	end

endmodule

`default_nettype wire

/* verilog/read_stage.sv */
// Issue to EX register; a load hazard stalls issue for one cycle and sends a bubble to EX
`timescale 1ns/100ps
`default_nettype none

module read_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  logic                 writes_rd,
	input  pipe_pkg::phys_idx_t  rd_phys,
	input  logic                 is_load,
	input  logic                 is_store,
	input  logic                 use_imm,
	input  pipe_pkg::alu_op_t    alu_op,
	input  pipe_pkg::imm_t       imm,
	input  pipe_pkg::data_word_t rs_data,
	input  pipe_pkg::data_word_t rt_data,
	input  logic                 load_hazard,
	output logic                 issue_ready,
	output logic                 ex_valid,
	output logic                 ex_writes,
	output logic                 ex_is_load,
	output logic                 ex_is_store,
	output logic                 ex_use_imm,
	output pipe_pkg::phys_idx_t  ex_rd,
	output pipe_pkg::alu_op_t    ex_op,
	output pipe_pkg::imm_t       ex_imm,
	output pipe_pkg::data_word_t ex_rs_data,
	output pipe_pkg::data_word_t ex_rt_data
);
	import pipe_pkg::*;

	logic accept;

	// Only the load hazard stalls issue
	assign issue_ready = ~load_hazard;
	assign accept      = issue_valid & issue_ready;

	// Valid bit; a stall or idle issue leaves a bubble
	always_ff @(posedge clk)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= accept;
	end

	// Payload only meaningful with ex_valid
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			ex_writes   <= writes_rd;
			ex_is_load  <= is_load;
			ex_is_store <= is_store;
			ex_use_imm  <= use_imm;
			ex_rd       <= rd_phys;
			ex_op       <= alu_op;
			ex_imm      <= imm;
			// Forwarded operands captured here
			ex_rs_data  <= rs_data;
			ex_rt_data  <= rt_data;
		end
	end

	// Memory access is either a load or a store, never both
	a_mem_kind: assert property (@(posedge clk) disable iff (reset)
		accept |-> !(is_load && is_store));

endmodule

`default_nettype wire

/* verilog/forward_unit.sv */
// Priority EX > MEM > WB > register file; load hazard checked against the EX load only
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
	input  logic                 uses_rs,
	input  logic                 uses_rt,
	input  pipe_pkg::phys_idx_t  rs_phys,
	input  pipe_pkg::phys_idx_t  rt_phys,
	input  pipe_pkg::data_word_t rs_value,
	input  pipe_pkg::data_word_t rt_value,
	input  logic                 ex_valid,
	input  logic                 ex_writes,
	input  logic                 ex_is_load,
	input  pipe_pkg::phys_idx_t  ex_rd,
	input  pipe_pkg::data_word_t ex_result,
	input  logic                 mem_valid,
	input  logic                 mem_writes,
	input  pipe_pkg::phys_idx_t  mem_rd,
	input  pipe_pkg::data_word_t mem_result,
	input  logic                 wb_valid,
	input  pipe_pkg::phys_idx_t  wb_phys,
	input  pipe_pkg::data_word_t wb_data,
	output pipe_pkg::data_word_t rs_data,
	output pipe_pkg::data_word_t rt_data,
	output logic                 load_hazard
);
	import pipe_pkg::*;

	logic ex_fwd;
	logic mem_fwd;
	logic ex_load;
	logic rs_hit_load;
	logic rt_hit_load;

	// EX result is not ready yet for a load
	assign ex_fwd  = ex_valid & ex_writes & ~ex_is_load;
	assign ex_load = ex_valid & ex_writes & ex_is_load;
	// MEM already carries load data
	assign mem_fwd = mem_valid & mem_writes;

	// Newest source wins for rs
	always_comb
	begin
		if (uses_rs && ex_fwd && ex_rd == rs_phys)
			rs_data = ex_result;
		else if (uses_rs && mem_fwd && mem_rd == rs_phys)
			rs_data = mem_result;
		else if (uses_rs && wb_valid && wb_phys == rs_phys)
			rs_data = wb_data;
		else
			rs_data = rs_value;
	end

	// Same chain for rt
	always_comb
	begin
		if (uses_rt && ex_fwd && ex_rd == rt_phys)
			rt_data = ex_result;
		else if (uses_rt && mem_fwd && mem_rd == rt_phys)
			rt_data = mem_result;
		else if (uses_rt && wb_valid && wb_phys == rt_phys)
			rt_data = wb_data;
		else
			rt_data = rt_value;
	end

	// Load in EX feeding a used source needs one bubble
	assign rs_hit_load = uses_rs & (rs_phys == ex_rd);
	assign rt_hit_load = uses_rt & (rt_phys == ex_rd);
	assign load_hazard = ex_load & (rs_hit_load | rt_hit_load);

endmodule

`default_nettype wire

/* verilog/phys_reg_file.sv */
// Two async read ports with no write bypass, so same-cycle writes reach readers via forwarding only
`timescale 1ns/100ps
`default_nettype none

`include "pipe_cfg.svh"

module phys_reg_file (
	input  logic                 clk,
	input  logic                 reset,
	input  pipe_pkg::phys_idx_t  rs_phys,
	input  pipe_pkg::phys_idx_t  rt_phys,
	output pipe_pkg::data_word_t rs_value,
	output pipe_pkg::data_word_t rt_value,
	input  logic                 wr_en,
	input  pipe_pkg::phys_idx_t  wr_phys,
	input  pipe_pkg::data_word_t wr_data
);
	import pipe_pkg::*;

	data_word_t regs [`PIPE_PHYS_REGS];

	// Whole file cleared on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PIPE_PHYS_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wr_phys] <= wr_data;
		end
	end

	// Old value seen during a write cycle
	assign rs_value = regs[rs_phys];
	assign rt_value = regs[rt_phys];

	// WB port must name a real register whenever it writes
	a_wr_idx_known: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> !$isunknown(wr_phys));

endmodule

`default_nettype wire

/* common/pipe_pkg.sv */
// Types only; widths come from pipe_cfg.svh, which must be on the include path
`default_nettype none

`include "pipe_cfg.svh"

package pipe_pkg;

	// Operand and result word
	typedef logic [`PIPE_DATA_WIDTH-1:0] data_word_t;

	// Index into the physical register file
	typedef logic [`PIPE_PHYS_BITS-1:0] phys_idx_t;

	// Word address into the data memory
	typedef logic [`PIPE_ADDR_BITS-1:0] mem_addr_t;

	// Immediate that EX sign extends
	typedef logic signed [`PIPE_IMM_WIDTH-1:0] imm_t;

	// ALU operations
	// Loads and stores use ALU_ADD for the address
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_t;

endpackage

`default_nettype wire

/* common/pipe_cfg.svh */
// Sizes are fixed at compile time; PIPE_PHYS_BITS and PIPE_ADDR_BITS must match log2 of the counts
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Data path word
`define PIPE_DATA_WIDTH 32

// Physical register file
`define PIPE_PHYS_REGS 32
`define PIPE_PHYS_BITS 5

// Word addressed data memory
`define PIPE_MEM_WORDS 64
`define PIPE_ADDR_BITS 6
`define PIPE_IMM_WIDTH 16

`endif
